// ==== hw/clkPkg.sv ====
`default_nettype none

package clkPkg;

  // Field widths fixed by the diagnostic bus format
  localparam int DIAG_SEL_W    = 3;
  localparam int EBUS_DATA_W   = 4;
  localparam int EBUS_WORD_W   = 6;
  localparam int BURST_COUNT_W = 8;
  localparam int RATE_SEL_W    = 2;
  localparam int CRAM_TIME_W   = 2;
  localparam int MBOX_COUNT_W  = 3;
  localparam int RATE_CNT_W    = 3;

  // Bus bits are numbered big-endian on the bus, so bus bit 35 lands in bit 0 here
  typedef logic [DIAG_SEL_W-1:0]    diagSelT;
  typedef logic [EBUS_DATA_W-1:0]   ebusDataT;
  typedef logic [EBUS_WORD_W-1:0]   ebusWordT;
  typedef logic [BURST_COUNT_W-1:0] burstCountT;
  typedef logic [RATE_SEL_W-1:0]    rateSelT;
  typedef logic [CRAM_TIME_W-1:0]   cramTimeT;
  typedef logic [MBOX_COUNT_W-1:0]  mboxCountT;

  typedef enum logic [1:0] {
    IDLE,
    RUNNING,
    BURSTING,
    STEPPING
  } clkRunStateT;

  // Control functions, strobed by ctlFunc
  localparam diagSelT FUNC_STOP        = 3'd0;
  localparam diagSelT FUNC_START       = 3'd1;
  localparam diagSelT FUNC_SINGLE_STEP = 3'd2;
  localparam diagSelT FUNC_BURST       = 3'd5;

  // Load functions, strobed by ldFunc
  localparam diagSelT LD_BURST_LSB = 3'd2;
  localparam diagSelT LD_BURST_MSB = 3'd3;
  localparam diagSelT LD_RATE      = 3'd4;
  localparam diagSelT LD_DISABLES  = 3'd5;

  // Readback selects
  localparam diagSelT RD_RUN      = 3'd0;
  localparam diagSelT RD_BURST_HI = 3'd1;
  localparam diagSelT RD_BURST_LO = 3'd2;
  localparam diagSelT RD_SYNC     = 3'd3;

  // Rate mask per rateSel, one tick every 2**rateSel cycles
  localparam logic [3:0][RATE_CNT_W-1:0] RATE_MASK = {3'b111, 3'b011, 3'b001, 3'b000};

  // MBOX ticks needed before sync, cramTime plus 1
  localparam logic [3:0][MBOX_COUNT_W-1:0] SYNC_COUNT = {3'd4, 3'd3, 3'd2, 3'd1};
  localparam mboxCountT MBOX_COUNT_MAX = 3'd7;

endpackage

`default_nettype wire

// ==== hw/diagFuncDecode.sv ====
`default_nettype none

module diagFuncDecode
  import clkPkg::*;
(
  input  logic    ctlFunc,
  input  logic    ldFunc,
  input  diagSelT diagSel,
  output logic    funcStart,
  output logic    funcStop,
  output logic    funcStep,
  output logic    funcBurst,
  output logic    ldBurstLsb,
  output logic    ldBurstMsb,
  output logic    ldRate,
  output logic    ldDisables
);

  // Pulses follow the strobe in the same cycle
  always_comb begin
    funcStart  = 1'b0;
    funcStop   = 1'b0;
    funcStep   = 1'b0;
    funcBurst  = 1'b0;
    ldBurstLsb = 1'b0;
    ldBurstMsb = 1'b0;
    ldRate     = 1'b0;
    ldDisables = 1'b0;
    // Control strobe wins if both strobes arrive together
    if (ctlFunc) begin
      case (diagSel)
        FUNC_STOP:        funcStop  = 1'b1;
        FUNC_START:       funcStart = 1'b1;
        FUNC_SINGLE_STEP: funcStep  = 1'b1;
        FUNC_BURST:       funcBurst = 1'b1;
        // Remaining control codes do nothing on this board
        default: ;
      endcase
    end else if (ldFunc) begin
      case (diagSel)
        LD_BURST_LSB: ldBurstLsb = 1'b1;
        LD_BURST_MSB: ldBurstMsb = 1'b1;
        LD_RATE:      ldRate     = 1'b1;
        LD_DISABLES:  ldDisables = 1'b1;
        default: ;
      endcase
    end
  end

  // Downstream blocks rely on never seeing two functions at once
  onePulseMax: assert final ($onehot0({funcStart, funcStop, funcStep, funcBurst,
                                       ldBurstLsb, ldBurstMsb, ldRate, ldDisables}));

endmodule

`default_nettype wire

// ==== hw/clkConfigRegs.sv ====
`default_nettype none

module clkConfigRegs
  import clkPkg::*;
(
  input  logic     MAIN_SOURCE,
  input  logic     rstN,
  input  logic     ldRate,
  input  logic     ldDisables,
  input  ebusDataT ebusIn,
  output rateSelT  rateSel,
  output logic     crmDis,
  output logic     edpDis,
  output logic     ctlDis
);

  // Rate select from bus bits 34-35
  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      rateSel <= '0;
    end else if (ldRate) begin
      rateSel <= ebusIn[1:0];
    end
  end

  // EBOX section clock disables
  // bus bit 33 is CRM, 34 is EDP, 35 is CTL
  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else if (ldDisables) begin
      crmDis <= ebusIn[2];
      edpDis <= ebusIn[1];
      ctlDis <= ebusIn[0];
    end
  end

endmodule

`default_nettype wire

// ==== hw/burstControl.sv ====
`default_nettype none

module burstControl
  import clkPkg::*;
(
  input  logic        MAIN_SOURCE,
  input  logic        rstN,
  input  logic        funcStart,
  input  logic        funcStop,
  input  logic        funcStep,
  input  logic        funcBurst,
  input  logic        ldBurstLsb,
  input  logic        ldBurstMsb,
  input  logic        ldRate,
  input  ebusDataT    ebusIn,
  input  rateSelT     rateSel,
  output clkRunStateT runState,
  output burstCountT  burstCount,
  output logic        mboxTick
);

  logic [RATE_CNT_W-1:0] rateCnt;
  logic                  rateTick;
  logic                  countZero;
  logic                  gatedEn;
  clkRunStateT           stateNext;

  // Free-running rate divider, restarted when a new rate is loaded
  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      rateCnt <= '0;
    end else if (ldRate) begin
      rateCnt <= '0;
    end else begin
      rateCnt <= rateCnt + 1'b1;
    end
  end

  // Tick when the low rateSel bits of the counter are all ones
  assign rateTick = (rateCnt & RATE_MASK[rateSel]) == RATE_MASK[rateSel];

  assign countZero = (burstCount == '0);

  // Clock gate enable, a burst only runs while count remains
  assign gatedEn = rateTick & ((runState == RUNNING) |
                               (runState == STEPPING) |
                               ((runState == BURSTING) & ~countZero));

  // Run-state FSM
  always_comb begin
    stateNext = runState;
    if (funcStop) begin
      stateNext = IDLE;
    end else if (funcStart) begin
      stateNext = RUNNING;
    end else if (funcStep) begin
      stateNext = STEPPING;
    end else if (funcBurst) begin
      stateNext = BURSTING;
    end else begin
      case (runState)
        // One gated cycle, then back to idle
        STEPPING: if (gatedEn) stateNext = IDLE;
        BURSTING: if (countZero) stateNext = IDLE;
        default: ;
      endcase
    end
  end

  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      runState <= IDLE;
    end else begin
      runState <= stateNext;
    end
  end

  // Burst counter, nibble loads beat the decrement
  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      burstCount <= '0;
    end else if (ldBurstLsb) begin
      burstCount[3:0] <= ebusIn;
    end else if (ldBurstMsb) begin
      burstCount[7:4] <= ebusIn;
    end else if ((runState == BURSTING) && gatedEn) begin
      burstCount <= burstCount - 1'b1;
    end
  end

  // MBOX tick lands one cycle after the gate enable
  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      mboxTick <= 1'b0;
    end else begin
      mboxTick <= gatedEn;
    end
  end

  // An idle board never counts on its own
  idleCountHeld: assert property (@(posedge MAIN_SOURCE) disable iff (!rstN)
    (runState == IDLE) && !ldBurstLsb && !ldBurstMsb |=> $stable(burstCount));

endmodule

`default_nettype wire

// ==== hw/eboxSyncGen.sv ====
`default_nettype none

module eboxSyncGen
  import clkPkg::*;
(
  input  logic     MAIN_SOURCE,
  input  logic     rstN,
  input  logic     mboxTick,
  input  cramTimeT cramTime,
  input  logic     mboxWait,
  input  logic     mboxResp,
  input  logic     crmDis,
  input  logic     edpDis,
  input  logic     ctlDis,
  output logic     eboxSync,
  output logic     eboxClk,
  output logic     crmClkEn,
  output logic     edpClkEn,
  output logic     ctlClkEn
);

  mboxCountT mboxCount;
  logic      memReady;
  logic      syncEn;
  logic      fireClk;

  // MBOX ticks since the last EBOX clock, held at 7
  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      mboxCount <= '0;
    end else if (eboxClk) begin
      mboxCount <= '0;
    end else if (mboxTick && (mboxCount != MBOX_COUNT_MAX)) begin
      mboxCount <= mboxCount + 1'b1;
    end
  end

  // A pending memory cycle stalls sync until the response shows up
  assign memReady = ~mboxWait | mboxResp;

  // Time-field compare
  assign syncEn = (mboxCount >= SYNC_COUNT[cramTime]) & ~eboxSync & memReady;

  // Second tick after sync issues the EBOX clock
  assign fireClk = mboxTick & eboxSync;

  // Sync point, one MBOX tick ahead of the EBOX clock
  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      eboxSync <= 1'b0;
    end else if (fireClk) begin
      eboxSync <= 1'b0;
    end else if (mboxTick && syncEn) begin
      eboxSync <= 1'b1;
    end
  end

  // EBOX clock and section enables, one cycle wide
  always_ff @(posedge MAIN_SOURCE) begin
    if (!rstN) begin
      eboxClk  <= 1'b0;
      crmClkEn <= 1'b0;
      edpClkEn <= 1'b0;
      ctlClkEn <= 1'b0;
    end else begin
      eboxClk  <= fireClk;
      crmClkEn <= fireClk & ~crmDis;
      edpClkEn <= fireClk & ~edpDis;
      ctlClkEn <= fireClk & ~ctlDis;
    end
  end

  // EBOX clock only comes out of a sync point
  clkAfterSync: assert property (@(posedge MAIN_SOURCE) disable iff (!rstN)
    eboxClk |-> $past(eboxSync));

  // Sections never clock on their own
  enNeedsClk: assert property (@(posedge MAIN_SOURCE) disable iff (!rstN)
    $rose(crmClkEn) || $rose(edpClkEn) || $rose(ctlClkEn) |-> eboxClk);

endmodule

`default_nettype wire

// ==== hw/diagReadMux.sv ====
`default_nettype none

module diagReadMux
  import clkPkg::*;
(
  input  logic        readFunc,
  input  diagSelT     diagSel,
  input  clkRunStateT runState,
  input  burstCountT  burstCount,
  input  rateSelT     rateSel,
  input  logic        eboxSync,
  input  logic        crmDis,
  input  logic        edpDis,
  input  logic        ctlDis,
  output ebusWordT    ebusOut,
  output logic        ebusDriving
);

  logic running;
  logic bursting;
  logic stepping;
  logic countZero;

  assign running   = (runState == RUNNING);
  assign bursting  = (runState == BURSTING);
  assign stepping  = (runState == STEPPING);
  assign countZero = (burstCount == '0);

  assign ebusDriving = readFunc;

  // Bit 5 is bus bit 30
  always_comb begin
    ebusOut = '0;
    if (readFunc) begin
      case (diagSel)
        RD_RUN:      ebusOut = {running, bursting, countZero, stepping, rateSel};
        RD_BURST_HI: ebusOut = {2'b00, burstCount[7:4]};
        RD_BURST_LO: ebusOut = {2'b00, burstCount[3:0]};
        RD_SYNC:     ebusOut = {eboxSync, 2'b00, crmDis, edpDis, ctlDis};
        // Unused selects read back zero
        default:     ebusOut = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/clkBoard.sv ====
`default_nettype none

module clkBoard
  import clkPkg::*;
(
  input  logic     MAIN_SOURCE,
  input  logic     rstN,
  input  logic     ctlFunc,
  input  logic     ldFunc,
  input  logic     readFunc,
  input  diagSelT  diagSel,
  input  ebusDataT ebusIn,
  input  cramTimeT cramTime,
  input  logic     mboxWait,
  input  logic     mboxResp,
  output ebusWordT ebusOut,
  output logic     ebusDriving,
  output logic     mboxTick,
  output logic     eboxSync,
  output logic     eboxClk,
  output logic     crmClkEn,
  output logic     edpClkEn,
  output logic     ctlClkEn
);

  // Function pulses
  logic funcStart, funcStop, funcStep, funcBurst;
  logic ldBurstLsb, ldBurstMsb, ldRate, ldDisables;

  // Configuration and run status
  rateSelT     rateSel;
  logic        crmDis, edpDis, ctlDis;
  clkRunStateT runState;
  burstCountT  burstCount;

  diagFuncDecode uDecode (
    .ctlFunc(ctlFunc), .ldFunc(ldFunc), .diagSel(diagSel),
    .funcStart(funcStart), .funcStop(funcStop), .funcStep(funcStep), .funcBurst(funcBurst),
    .ldBurstLsb(ldBurstLsb), .ldBurstMsb(ldBurstMsb), .ldRate(ldRate), .ldDisables(ldDisables)
  );

  clkConfigRegs uConfig (
    .MAIN_SOURCE(MAIN_SOURCE), .rstN(rstN), .ldRate(ldRate), .ldDisables(ldDisables),
    .ebusIn(ebusIn), .rateSel(rateSel), .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis)
  );

  burstControl uBurst (
    .MAIN_SOURCE(MAIN_SOURCE), .rstN(rstN),
    .funcStart(funcStart), .funcStop(funcStop), .funcStep(funcStep), .funcBurst(funcBurst),
    .ldBurstLsb(ldBurstLsb), .ldBurstMsb(ldBurstMsb), .ldRate(ldRate), .ebusIn(ebusIn),
    .rateSel(rateSel), .runState(runState), .burstCount(burstCount), .mboxTick(mboxTick)
  );

  eboxSyncGen uSync (
    .MAIN_SOURCE(MAIN_SOURCE), .rstN(rstN), .mboxTick(mboxTick), .cramTime(cramTime),
    .mboxWait(mboxWait), .mboxResp(mboxResp),
    .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .eboxSync(eboxSync), .eboxClk(eboxClk),
    .crmClkEn(crmClkEn), .edpClkEn(edpClkEn), .ctlClkEn(ctlClkEn)
  );

  diagReadMux uReadMux (
    .readFunc(readFunc), .diagSel(diagSel), .runState(runState), .burstCount(burstCount),
    .rateSel(rateSel), .eboxSync(eboxSync), .crmDis(crmDis), .edpDis(edpDis), .ctlDis(ctlDis),
    .ebusOut(ebusOut), .ebusDriving(ebusDriving)
  );

endmodule

`default_nettype wire

// ==== testbench/tbClockGen.sv ====
`default_nettype none

module tbClockGen (
  output logic MAIN_SOURCE,
  output logic rstN
);

  localparam int HALF_PERIOD  = 2;
  localparam int RESET_CYCLES = 10;

  // Free-running clock, period 4
  initial begin
    MAIN_SOURCE = 1'b0;
    forever #HALF_PERIOD MAIN_SOURCE = ~MAIN_SOURCE;
  end

  // Reset low for the first cycles, released on a rising edge
  initial begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge MAIN_SOURCE);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== testbench/clkBoardChecker.sv ====
`default_nettype none

module clkBoardChecker
  import clkPkg::*;
(
  input  logic     MAIN_SOURCE,
  input  logic     rstN,
  input  logic     ctlFunc,
  input  logic     ldFunc,
  input  logic     readFunc,
  input  diagSelT  diagSel,
  input  ebusDataT ebusIn,
  input  cramTimeT cramTime,
  input  logic     mboxWait,
  input  logic     mboxResp,
  input  ebusWordT ebusOut,
  input  logic     ebusDriving,
  input  logic     mboxTick,
  input  logic     eboxSync,
  input  logic     eboxClk,
  input  logic     crmClkEn,
  input  logic     edpClkEn,
  input  logic     ctlClkEn,
  input  logic     runDone,
  output int       errorCount,
  output logic     reportDone
);

  // Board model
  logic [1:0]  mRate;
  logic [2:0]  mDis;      // crm, edp, ctl
  logic [2:0]  mRateCnt;
  clkRunStateT mState;
  logic [7:0]  mCount;
  logic        mTick;
  logic        mSync;
  logic        mClk;
  logic [2:0]  mEn;       // crm, edp, ctl
  int unsigned mMbox;

  int checks      = 0;
  int valueErrors = 0;
  int otherErrors = 0;
  int clkSeen     = 0;

  assign errorCount = valueErrors + otherErrors;

  initial reportDone = 1'b0;

  task automatic checkSignal(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      valueErrors++;
      $display("[ERROR] t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // Step the model with the inputs seen at this edge
  always @(posedge MAIN_SOURCE) begin
    logic [2:0] mask;
    logic       gated;
    logic       fire;
    logic       syncOk;
    logic       zero;
    if (!rstN) begin
      mRate    = '0;
      mDis     = '0;
      mRateCnt = '0;
      mState   = IDLE;
      mCount   = '0;
      mTick    = 1'b0;
      mSync    = 1'b0;
      mClk     = 1'b0;
      mEn      = '0;
      mMbox    = 0;
    end else begin
      // One tick every 2**rate cycles
      mask   = 3'((1 << mRate) - 1);
      zero   = (mCount == 8'd0);
      gated  = ((mRateCnt & mask) == mask) &&
               (mState == RUNNING || mState == STEPPING || (mState == BURSTING && !zero));
      fire   = mTick && mSync;
      // Sync needs cramTime plus 1 ticks and no stalled memory cycle
      syncOk = (mMbox >= cramTime + 1) && !mSync && (!mboxWait || mboxResp);
      // EBOX side
      if (mClk) begin
        mMbox = 0;
      end else if (mTick && mMbox < 7) begin
        mMbox = mMbox + 1;
      end
      if (fire) begin
        mSync = 1'b0;
      end else if (mTick && syncOk) begin
        mSync = 1'b1;
      end
      mClk  = fire;
      mEn   = fire ? ~mDis : 3'b000;
      mTick = gated;
      // Burst count, loads beat the decrement
      if (ldFunc && !ctlFunc && diagSel == LD_BURST_LSB) begin
        mCount[3:0] = ebusIn;
      end else if (ldFunc && !ctlFunc && diagSel == LD_BURST_MSB) begin
        mCount[7:4] = ebusIn;
      end else if (mState == BURSTING && gated) begin
        mCount = mCount - 8'd1;
      end
      // Run state
      if (ctlFunc && diagSel == FUNC_STOP) begin
        mState = IDLE;
      end else if (ctlFunc && diagSel == FUNC_START) begin
        mState = RUNNING;
      end else if (ctlFunc && diagSel == FUNC_SINGLE_STEP) begin
        mState = STEPPING;
      end else if (ctlFunc && diagSel == FUNC_BURST) begin
        mState = BURSTING;
      end else if ((mState == STEPPING && gated) || (mState == BURSTING && zero)) begin
        mState = IDLE;
      end
      // Rate divider restarts on a rate load
      mRateCnt = (ldFunc && !ctlFunc && diagSel == LD_RATE) ? 3'd0 : mRateCnt + 3'd1;
      if (ldFunc && !ctlFunc && diagSel == LD_RATE) begin
        mRate = ebusIn[1:0];
      end
      if (ldFunc && !ctlFunc && diagSel == LD_DISABLES) begin
        mDis = ebusIn[2:0];
      end
    end
  end

  // Outputs are settled by the falling edge
  always @(negedge MAIN_SOURCE) begin
    ebusWordT expOut;
    if (rstN) begin
      expOut = '0;
      if (readFunc) begin
        case (diagSel)
          RD_RUN:      expOut = {mState == RUNNING, mState == BURSTING, mCount == 8'd0,
                                 mState == STEPPING, mRate};
          RD_BURST_HI: expOut = {2'b00, mCount[7:4]};
          RD_BURST_LO: expOut = {2'b00, mCount[3:0]};
          RD_SYNC:     expOut = {mSync, 2'b00, mDis};
          default:     expOut = '0;
        endcase
      end
      checkSignal("ebusOut", 8'(ebusOut), 8'(expOut));
      checkSignal("ebusDriving", 8'(ebusDriving), 8'(readFunc));
      checkSignal("mboxTick", 8'(mboxTick), 8'(mTick));
      checkSignal("eboxSync", 8'(eboxSync), 8'(mSync));
      checkSignal("eboxClk", 8'(eboxClk), 8'(mClk));
      checkSignal("crmClkEn", 8'(crmClkEn), 8'(mEn[2]));
      checkSignal("edpClkEn", 8'(edpClkEn), 8'(mEn[1]));
      checkSignal("ctlClkEn", 8'(ctlClkEn), 8'(mEn[0]));
      if (eboxClk === 1'b1) begin
        clkSeen++;
      end
    end
    if (runDone && !reportDone) begin
      // A run without any EBOX clock exercised too little
      if (clkSeen == 0) begin
        otherErrors++;
        $display("No EBOX clock was issued during the whole run");
      end
      $display("Checks %0d, value errors %0d, other errors %0d, EBOX clocks %0d",
               checks, valueErrors, otherErrors, clkSeen);
      reportDone = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/clkBoardTb.sv ====
`default_nettype none

module clkBoardTb
  import clkPkg::*;
();

  localparam int PERIOD        = 4;
  localparam int RUN_CYCLES    = 4000;
  localparam int WATCHDOG_TIME = (RUN_CYCLES + 100) * PERIOD;

  logic     MAIN_SOURCE;
  logic     rstN;
  logic     ctlFunc;
  logic     ldFunc;
  logic     readFunc;
  diagSelT  diagSel;
  ebusDataT ebusIn;
  cramTimeT cramTime;
  logic     mboxWait;
  logic     mboxResp;
  ebusWordT ebusOut;
  logic     ebusDriving;
  logic     mboxTick;
  logic     eboxSync;
  logic     eboxClk;
  logic     crmClkEn;
  logic     edpClkEn;
  logic     ctlClkEn;
  logic     runDone;
  logic     reportDone;
  int       errorCount;

  logic [31:0] lfsr = 32'h410095c7;

  // Taps for x^32 + x^22 + x^2 + x + 1
  // One step per bit
  function automatic logic lfsrBit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] randBits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsrBit()};
    end
    return v;
  endfunction

  // One cycle of random stimulus with single-cycle strobes
  task automatic driveCycle();
    logic [7:0] pick;
    diagSelT    sel;
    ebusDataT   data;
    logic       ctl;
    logic       ld;
    pick = randBits(6);
    sel  = diagSelT'(randBits(3));
    data = ebusDataT'(randBits(4));
    ctl  = 1'b0;
    ld   = 1'b0;
    if (pick == 0) begin
      ctl = 1'b1;
      case (randBits(2))
        8'd0:    sel = FUNC_STOP;
        8'd1:    sel = FUNC_START;
        8'd2:    sel = FUNC_SINGLE_STEP;
        default: sel = FUNC_BURST;
      endcase
    end else if (pick < 4) begin
      ld  = 1'b1;
      sel = diagSelT'(LD_BURST_LSB + randBits(2));
      // Small high nibble so bursts can finish between control strobes
      if (sel == LD_BURST_MSB) begin
        data = ebusDataT'(randBits(1));
      end
    end
    ctlFunc  <= ctl;
    ldFunc   <= ld;
    diagSel  <= sel;
    ebusIn   <= data;
    readFunc <= (randBits(2) == 0);
    if (randBits(4) == 0) begin
      cramTime <= cramTimeT'(randBits(2));
    end
    // Memory wait toggles slowly while the response comes and goes
    if (randBits(4) == 0) begin
      mboxWait <= ~mboxWait;
    end
    mboxResp <= (randBits(2) == 0);
  endtask

  tbClockGen clockGen (
    .MAIN_SOURCE(MAIN_SOURCE),
    .rstN(rstN)
  );

  clkBoard uut (
    .MAIN_SOURCE(MAIN_SOURCE), .rstN(rstN), .ctlFunc(ctlFunc), .ldFunc(ldFunc),
    .readFunc(readFunc), .diagSel(diagSel), .ebusIn(ebusIn), .cramTime(cramTime),
    .mboxWait(mboxWait), .mboxResp(mboxResp), .ebusOut(ebusOut), .ebusDriving(ebusDriving),
    .mboxTick(mboxTick), .eboxSync(eboxSync), .eboxClk(eboxClk),
    .crmClkEn(crmClkEn), .edpClkEn(edpClkEn), .ctlClkEn(ctlClkEn)
  );

  clkBoardChecker scoreboard (
    .MAIN_SOURCE(MAIN_SOURCE), .rstN(rstN), .ctlFunc(ctlFunc), .ldFunc(ldFunc),
    .readFunc(readFunc), .diagSel(diagSel), .ebusIn(ebusIn), .cramTime(cramTime),
    .mboxWait(mboxWait), .mboxResp(mboxResp), .ebusOut(ebusOut), .ebusDriving(ebusDriving),
    .mboxTick(mboxTick), .eboxSync(eboxSync), .eboxClk(eboxClk),
    .crmClkEn(crmClkEn), .edpClkEn(edpClkEn), .ctlClkEn(ctlClkEn),
    .runDone(runDone), .errorCount(errorCount), .reportDone(reportDone)
  );

  initial begin
    ctlFunc  = 1'b0;
    ldFunc   = 1'b0;
    readFunc = 1'b0;
    diagSel  = '0;
    ebusIn   = '0;
    cramTime = '0;
    mboxWait = 1'b0;
    mboxResp = 1'b0;
    runDone  = 1'b0;
    wait (rstN === 1'b1);
    repeat (RUN_CYCLES) begin
      @(posedge MAIN_SOURCE);
      driveCycle();
    end
    // Quiet the strobes and let the scoreboard close out
    @(posedge MAIN_SOURCE);
    ctlFunc <= 1'b0;
    ldFunc  <= 1'b0;
    runDone <= 1'b1;
    wait (reportDone === 1'b1);
    // Error count settles with the closing line
    @(posedge MAIN_SOURCE);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout, the run did not finish within %0d time units", WATCHDOG_TIME);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== clkBoard.f ====
hw/clkPkg.sv
hw/diagFuncDecode.sv
hw/clkConfigRegs.sv
hw/burstControl.sv
hw/eboxSyncGen.sv
hw/diagReadMux.sv
hw/clkBoard.sv
testbench/tbClockGen.sv
testbench/clkBoardChecker.sv
testbench/clkBoardTb.sv
